/* project.f */
+incdir+common
common/rv64_pkg.sv
common/issue_if.sv
hw/fetch_stage.sv
hw/decode_unit.sv
hw/execute_stage.sv
hw/rv64_core.sv
testbench/core_chk.sv
testbench/core_tb.sv

/* run.sh */
#!/bin/sh
# build with Verilator, run, and judge the result from the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module core_tb -f project.f -o core_sim \
    && ./obj_dir/core_sim +verilator+error+limit+100 > sim.log 2>&1 \
    || echo "Simulation failed" >> sim.log

cat sim.log
if grep -q "Simulation failed" sim.log; then
    echo "FAIL"
    exit 1
fi
echo "PASS"
exit 0

/* testbench/core_tb.sv */
`timescale 1ns/1ps

module core_tb;

    localparam int memLines   = 256; // 64-bit lines, 2 KiB
    localparam int runTimeout = 5000;
    localparam int resultBase = 'h400;
    localparam int dataBase   = 'h600;
    localparam logic [63:0] fillTag = 64'hF00D_0000_0000_0000;
    localparam logic [31:0] ebreakWord = 32'h0010_0073;

    localparam int opImm   = 'b0010011;
    localparam int opReg   = 'b0110011;
    localparam int opReg32 = 'b0111011;
    localparam int opLoad  = 'b0000011;
    localparam int opLui   = 'b0110111;
    localparam int opAuipc = 'b0010111;
    localparam int opJalr  = 'b1100111;

    logic        clk;
    logic        arstN;
    logic        ibusCyc;
    logic        ibusStb;
    logic [63:0] ibusAdr;
    logic [31:0] ibusDatRd;
    logic        ibusAck;
    logic        dbusCyc;
    logic        dbusStb;
    logic        dbusWe;
    logic [7:0]  dbusSel;
    logic [63:0] dbusAdr;
    logic [63:0] dbusDatWr;
    logic [63:0] dbusDatRd;
    logic        dbusAck;
    logic        halted;
    logic        trap;

    logic [63:0] mem [memLines];
    logic [31:0] randState = 32'h8e47_9403;
    int          ibusWait = -1; // cycles left before ack, -1 when idle
    int          dbusWait = -1;
    logic [63:0] progPc;
    int          storeSlot;
    logic [63:0] expAdr [$];
    logic [63:0] expData [$];
    logic [7:0]  expLoadSel [$]; // byte lanes of each lw, in program order

    rv64_core rv64_core_inst (.*);

    always #4 clk = ~clk;

    task automatic abortRun(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1, "stopping at the first error");
    endtask

    function automatic int nextDelay();
        randState = randState * 32'd1664525 + 32'd1013904223;
        return int'(randState[31:30]); // 0 to 3 wait cycles
    endfunction

    // RV64I field packing
    function automatic logic [31:0] iType(input int imm, input int rs1, input int f3,
                                          input int rd, input int op);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
    endfunction

    function automatic logic [31:0] rType(input int f7, input int rs2, input int rs1,
                                          input int f3, input int rd, input int op);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
    endfunction

    function automatic logic [31:0] sType(input int imm, input int rs2, input int rs1);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b011, imm[4:0], 7'b0100011}; // sd
    endfunction

    function automatic logic [31:0] bType(input int imm, input int rs2, input int rs1,
                                          input int f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
                7'b1100011};
    endfunction

    function automatic logic [31:0] uType(input int imm, input int rd, input int op);
        return {imm[19:0], rd[4:0], op[6:0]};
    endfunction

    function automatic logic [31:0] jType(input int imm, input int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
    endfunction

    task automatic emit(input logic [31:0] word);
        if (progPc[2]) mem[progPc[10:3]][63:32] = word;
        else           mem[progPc[10:3]][31:0]  = word;
        progPc = progPc + 64'd4;
    endtask

    // sd rs2 to the next result slot, x10 holds the result base
    task automatic storeResult(input int rs2, input logic [63:0] value);
        emit(sType(storeSlot * 8, rs2, 10));
        expAdr.push_back(64'(resultBase + storeSlot * 8));
        expData.push_back(value);
        storeSlot++;
    endtask

    task automatic poisonStore();
        emit(sType('h3F8, 31, 10)); // must never execute
    endtask

    task automatic clearMemory();
        for (int i = 0; i < memLines; i++) mem[i] = fillTag | 64'(i);
        progPc    = '0;
        storeSlot = 0;
        expAdr.delete();
        expData.delete();
        expLoadSel.delete();
    endtask

    task automatic loadMainProgram();
        logic [63:0] auipcPc;
        logic [63:0] linkPc;
        clearMemory();
        mem[dataBase / 8] = 64'h1234_5678_8765_4321;
        emit(iType(100, 0, 0, 1, opImm));      // addi x1, x0, 100
        emit(iType(-7, 0, 0, 2, opImm));       // addi x2, x0, -7
        emit(iType(resultBase, 0, 0, 10, opImm));
        emit(rType(32, 2, 1, 0, 3, opReg));    // sub x3, x1, x2
        emit(uType('h7FFFF, 4, opLui));
        emit(iType('h7FF, 4, 0, 4, opImm));    // x4 = 0x7ffff7ff
        emit(rType(0, 4, 4, 0, 5, opReg32));   // addw x5, x4, x4 overflows bit 31
        emit(iType(40, 1, 1, 6, opImm));       // slli x6, x1, 40
        auipcPc = progPc;
        emit(uType('h12345, 7, opAuipc));
        emit(uType('hABCDE, 11, opLui));       // upper bit set, sign extends
        emit(iType(-1, 1, 3, 8, opImm));       // sltiu x8, x1, -1
        emit(iType(50, 1, 3, 9, opImm));       // sltiu x9, x1, 50
        storeResult(1, 64'd100);
        storeResult(2, 64'hFFFF_FFFF_FFFF_FFF9);
        storeResult(3, 64'd107);               // 100 - (-7)
        storeResult(5, 64'hFFFF_FFFF_FFFF_EFFE); // low word 0xffffeffe
        storeResult(6, 64'd100 << 40);
        storeResult(7, auipcPc + 64'h1234_5000);
        storeResult(11, 64'hFFFF_FFFF_ABCD_E000);
        storeResult(8, 64'd1);                 // imm reads as 2^64 - 1
        storeResult(9, 64'd0);
        emit(uType('hBAD00, 31, opLui));       // poison in x31
        emit(bType(8, 1, 1, 0));               // beq x1, x1 taken
        poisonStore();
        emit(bType(8, 2, 1, 1));               // bne x1, x2 taken
        poisonStore();
        emit(bType(8, 2, 1, 0));               // beq x1, x2 falls through
        emit(iType(55, 0, 0, 12, opImm));
        storeResult(12, 64'd55);
        linkPc = progPc;
        emit(jType(8, 13));                    // jal x13, +8
        poisonStore();
        storeResult(13, linkPc + 64'd4);
        emit(uType(0, 14, opAuipc));           // x14 = own pc
        linkPc = progPc;
        emit(iType(12, 14, 0, 15, opJalr));    // lands two words past the jalr
        poisonStore();
        storeResult(15, linkPc + 64'd4);
        emit(iType(dataBase, 0, 0, 17, opImm));
        emit(iType(0, 17, 2, 16, opLoad));     // lw x16, 0(x17) negative word
        emit(iType(4, 17, 2, 18, opLoad));     // lw x18, 4(x17) positive word
        expLoadSel.push_back(8'h0F);           // low word lanes
        expLoadSel.push_back(8'hF0);
        storeResult(16, 64'hFFFF_FFFF_8765_4321);
        storeResult(18, 64'h0000_0000_1234_5678);
        emit(ebreakWord);
    endtask

    task automatic checkStore();
        logic [63:0] wantAdr;
        logic [63:0] wantData;
        if (expData.size() == 0) begin
            abortRun("store seen after the last expected result");
        end else begin
            wantAdr  = expAdr.pop_front();
            wantData = expData.pop_front();
            assert (dbusAdr == wantAdr) else abortRun($sformatf(
                "mismatch at %0t: dbusAdr got %h expected %h", $time, dbusAdr, wantAdr));
            assert (dbusDatWr == wantData) else abortRun($sformatf(
                "mismatch at %0t: dbusDatWr got %h expected %h", $time, dbusDatWr, wantData));
            assert (dbusSel == 8'hFF) else abortRun($sformatf(
                "mismatch at %0t: dbusSel got %h expected %h", $time, dbusSel, 8'hFF));
        end
    endtask

    task automatic matchLoadSelect();
        logic [7:0] wantSel;
        if (expLoadSel.size() == 0) begin
            abortRun("load seen after the last expected load");
        end else begin
            wantSel = expLoadSel.pop_front();
            assert (dbusSel == wantSel) else abortRun($sformatf(
                "mismatch at %0t: dbusSel got %h expected %h", $time, dbusSel, wantSel));
        end
    endtask

    // memory model, answers both buses 1 ns after the edge
    always @(posedge clk) begin
        #1;
        if (!arstN) begin
            ibusAck  = 1'b0;
            dbusAck  = 1'b0;
            ibusWait = -1;
            dbusWait = -1;
        end else begin
            if (ibusAck) ibusAck = 1'b0;
            else if (ibusCyc && ibusStb) begin
                if (ibusWait < 0) ibusWait = nextDelay();
                if (ibusWait == 0) begin
                    ibusDatRd = ibusAdr[2] ? mem[ibusAdr[10:3]][63:32]
                                           : mem[ibusAdr[10:3]][31:0];
                    ibusAck   = 1'b1;
                end
                ibusWait = ibusWait - 1;
            end
            if (dbusAck) dbusAck = 1'b0;
            else if (dbusCyc && dbusStb) begin
                if (dbusWait < 0) dbusWait = nextDelay();
                if (dbusWait == 0) begin
                    if (dbusWe) begin
                        checkStore();
                        mem[dbusAdr[10:3]] = dbusDatWr;
                    end else begin
                        matchLoadSelect();
                        dbusDatRd = mem[dbusAdr[10:3]];
                    end
                    dbusAck = 1'b1;
                end
                dbusWait = dbusWait - 1;
            end
        end
    end

    always @(negedge clk) begin
        if (rv64_core_inst.busChkInst.failCount != 0)
            abortRun("a bound bus or store assertion failed");
    end

    initial begin
        int cycles;
        clk       = 1'b0;
        arstN     = 1'b0;
        ibusDatRd = '0;
        ibusAck   = 1'b0;
        dbusDatRd = '0;
        dbusAck   = 1'b0;
        loadMainProgram();
        repeat (10) @(posedge clk);
        #1 arstN = 1'b1;

        cycles = 0;
        while (!halted && !trap && cycles < runTimeout) begin
            @(negedge clk);
            cycles++;
        end
        if (!halted && !trap) abortRun("timeout while waiting for the main program to halt");
        assert (!trap) else abortRun("trap raised by the main program");
        repeat (20) @(negedge clk); // no fetch may follow ebreak
        assert (expData.size() == 0) else abortRun($sformatf(
            "%0d expected stores never appeared", expData.size()));

        // short run ending on an illegal word
        @(posedge clk);
        #1 arstN = 1'b0;
        clearMemory();
        emit(iType(1, 0, 0, 1, opImm));
        emit(32'h0000_0000); // matches no opcode
        repeat (10) @(posedge clk);
        #1 arstN = 1'b1;
        cycles = 0;
        while (!trap && !halted && cycles < runTimeout) begin
            @(negedge clk);
            cycles++;
        end
        if (!trap && !halted) abortRun("timeout while waiting for trap");
        assert (!halted) else abortRun("halted raised for an illegal instruction");
        repeat (20) @(negedge clk);

        if (rv64_core_inst.busChkInst.failCount == 0) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            abortRun("a bound bus or store assertion failed");
        end
    end

endmodule

/* testbench/core_chk.sv */
`timescale 1ns/1ps

module core_chk (
    input logic        clk,
    input logic        arstN,
    input logic        ibusCyc,
    input logic        ibusStb,
    input logic [63:0] ibusAdr,
    input logic        ibusAck,
    input logic        dbusCyc,
    input logic        dbusStb,
    input logic        dbusWe,
    input logic [63:0] dbusAdr,
    input logic [63:0] dbusDatWr,
    input logic        dbusAck,
    input logic        halted,
    input logic        trap
);

    localparam logic [63:0] poisonValue = 64'hFFFF_FFFF_BAD0_0000; // lui x31, 0xbad00

    int failCount = 0; // watched by the testbench top

    resetIdle: assert property (@(posedge clk) !arstN |-> !ibusCyc && !dbusCyc)
        else begin
            failCount++;
            $error("bus cycle active while reset is held");
        end

    // stb never without cyc, on either bus
    stbInCyc: assert property (@(posedge clk) disable iff (!arstN)
        (!ibusStb || ibusCyc) && (!dbusStb || dbusCyc))
        else begin
            failCount++;
            $error("stb high outside a bus cycle");
        end

    ibusHold: assert property (@(posedge clk) disable iff (!arstN)
        (ibusStb && !ibusAck) |=> ibusStb && $stable(ibusAdr))
        else begin
            failCount++;
            $error("instruction bus request changed before ack");
        end

    dbusHold: assert property (@(posedge clk) disable iff (!arstN)
        (dbusStb && !dbusAck) |=> dbusStb && $stable(dbusAdr) && $stable(dbusWe)
        && $stable(dbusDatWr))
        else begin
            failCount++;
            $error("data bus request changed before ack");
        end

    // classic cycles end right after the ack
    busRelease: assert property (@(posedge clk) disable iff (!arstN)
        (ibusStb && ibusAck) || (dbusStb && dbusAck) |=> !ibusCyc && !dbusCyc)
        else begin
            failCount++;
            $error("bus cycle held past its ack");
        end

    stopNoFetch: assert property (@(posedge clk) disable iff (!arstN)
        (halted || trap) |-> !ibusCyc)
        else begin
            failCount++;
            $error("instruction fetch after the core stopped");
        end

    noPoison: assert property (@(posedge clk) disable iff (!arstN)
        (dbusStb && dbusWe) |-> dbusDatWr != poisonValue)
        else begin
            failCount++;
            $error("store from a path that a branch or jump should skip");
        end

    resultArea: assert property (@(posedge clk) disable iff (!arstN)
        (dbusStb && dbusWe) |-> dbusAdr >= 64'h400 && dbusAdr < 64'h800)
        else begin
            failCount++;
            $error("store outside the result area");
        end

endmodule

bind rv64_core core_chk busChkInst (
    .clk       (clk),
    .arstN     (arstN),
    .ibusCyc   (ibusCyc),
    .ibusStb   (ibusStb),
    .ibusAdr   (ibusAdr),
    .ibusAck   (ibusAck),
    .dbusCyc   (dbusCyc),
    .dbusStb   (dbusStb),
    .dbusWe    (dbusWe),
    .dbusAdr   (dbusAdr),
    .dbusDatWr (dbusDatWr),
    .dbusAck   (dbusAck),
    .halted    (halted),
    .trap      (trap)
);

/* hw/rv64_core.sv */
`timescale 1ns/1ps

module rv64_core (
    input  logic        clk,
    input  logic        arstN,
    // instruction bus
    output logic        ibusCyc,
    output logic        ibusStb,
    output logic [63:0] ibusAdr,
    input  logic [31:0] ibusDatRd,
    input  logic        ibusAck,
    // data bus
    output logic        dbusCyc,
    output logic        dbusStb,
    output logic        dbusWe,
    output logic [7:0]  dbusSel,
    output logic [63:0] dbusAdr,
    output logic [63:0] dbusDatWr,
    input  logic [63:0] dbusDatRd,
    input  logic        dbusAck,
    output logic        halted,
    output logic        trap
);

    logic             instValid;
    rv64_pkg::instT   inst;
    rv64_pkg::xlenT   instPc;
    logic             retireValid;
    rv64_pkg::xlenT   nextPc;
    logic             wbEn;
    rv64_pkg::regIdxT wbRd;
    rv64_pkg::xlenT   wbData;
    wire              stop = halted | trap; // either status freezes fetch

    issue_if issueBus ();

    fetch_stage fetchInst (
        .clk         (clk),
        .arstN       (arstN),
        .retireValid (retireValid),
        .nextPc      (nextPc),
        .stop        (stop),
        .ibusCyc     (ibusCyc),
        .ibusStb     (ibusStb),
        .ibusAdr     (ibusAdr),
        .ibusDatRd   (ibusDatRd),
        .ibusAck     (ibusAck),
        .instValid   (instValid),
        .inst        (inst),
        .instPc      (instPc)
    );

    decode_unit decodeInst (
        .clk       (clk),
        .arstN     (arstN),
        .instValid (instValid),
        .inst      (inst),
        .instPc    (instPc),
        .wbEn      (wbEn),
        .wbRd      (wbRd),
        .wbData    (wbData),
        .issue     (issueBus.issuer)
    );

    execute_stage executeInst (
        .clk         (clk),
        .arstN       (arstN),
        .issue       (issueBus.executor),
        .retireValid (retireValid),
        .nextPc      (nextPc),
        .wbEn        (wbEn),
        .wbRd        (wbRd),
        .wbData      (wbData),
        .halted      (halted),
        .trap        (trap),
        .dbusCyc     (dbusCyc),
        .dbusStb     (dbusStb),
        .dbusWe      (dbusWe),
        .dbusSel     (dbusSel),
        .dbusAdr     (dbusAdr),
        .dbusDatWr   (dbusDatWr),
        .dbusDatRd   (dbusDatRd),
        .dbusAck     (dbusAck)
    );

endmodule

/* hw/execute_stage.sv */
`timescale 1ns/1ps

module execute_stage (
    input  logic             clk,
    input  logic             arstN,
    issue_if.executor        issue,
    output logic             retireValid,
    output rv64_pkg::xlenT   nextPc,
    output logic             wbEn,
    output rv64_pkg::regIdxT wbRd,
    output rv64_pkg::xlenT   wbData,
    output logic             halted,
    output logic             trap,
    output logic             dbusCyc,
    output logic             dbusStb,
    output logic             dbusWe,
    output logic [7:0]       dbusSel,
    output rv64_pkg::xlenT   dbusAdr,
    output rv64_pkg::xlenT   dbusDatWr,
    input  rv64_pkg::xlenT   dbusDatRd,
    input  logic             dbusAck
);

    typedef enum logic [1:0] {
        idle,
        memWait,
        retire
    } stateE;

    stateE          state;
    rv64_pkg::xlenT opA;
    rv64_pkg::xlenT opB;
    rv64_pkg::xlenT sum;
    rv64_pkg::xlenT aluResult;
    rv64_pkg::xlenT pcPlus4;
    rv64_pkg::xlenT branchTarget;
    rv64_pkg::xlenT loadData;
    logic           isEqual;
    logic           isLessU;

    // operand select
    assign opA = (issue.aluSrc == rv64_pkg::srcImmPc) ? issue.imm : issue.rs1Data;
    always_comb begin
        case (issue.aluSrc)
            rv64_pkg::srcRegImm: opB = issue.imm;
            rv64_pkg::srcImmPc:  opB = issue.pc;
            default:             opB = issue.rs2Data;
        endcase
    end

    assign sum = opA + opB;

    always_comb begin
        case (issue.aluOp)
            rv64_pkg::aluAdd:         aluResult = sum;
            rv64_pkg::aluAddClearLsb: aluResult = {sum[63:1], 1'b0};
            rv64_pkg::aluShiftLeft:   aluResult = opA << opB[5:0];
            rv64_pkg::aluAddWord:     aluResult = {{32{sum[31]}}, sum[31:0]};
            rv64_pkg::aluSub:         aluResult = opA - opB;
            default:                  aluResult = '0;
        endcase
    end

    // comparator, rs2 for branches and imm for sltiu
    assign isEqual = (issue.rs1Data == issue.rs2Data);
    assign isLessU = (issue.rs1Data < issue.imm);

    assign pcPlus4      = issue.pc + 64'd4;
    assign branchTarget = issue.pc + issue.imm;

    always_comb begin
        case (issue.pcSrc)
            rv64_pkg::pcJump:     nextPc = aluResult;
            rv64_pkg::pcBranchEq: nextPc = isEqual ? branchTarget : pcPlus4;
            rv64_pkg::pcBranchNe: nextPc = isEqual ? pcPlus4 : branchTarget;
            default:              nextPc = pcPlus4;
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state  <= idle;
            halted <= 1'b0;
            trap   <= 1'b0;
        end else begin
            case (state)
                idle: begin
                    if (issue.valid) begin
                        // stop flags rise before retirement so fetch stays put
                        if (issue.halt) halted <= 1'b1;
                        if (issue.illegal) trap <= 1'b1;
                        if (issue.memOp != rv64_pkg::memNone && !issue.halt && !issue.illegal)
                            state <= memWait;
                        else
                            state <= retire;
                    end
                end
                memWait: if (dbusAck) state <= retire;
                retire:  state <= idle;
                default: state <= idle;
            endcase
        end
    end

    // low or high word of the line, sign extended
    always_ff @(posedge clk) begin
        if (state == memWait && dbusAck) begin
            if (aluResult[2]) loadData <= {{32{dbusDatRd[63]}}, dbusDatRd[63:32]};
            else              loadData <= {{32{dbusDatRd[31]}}, dbusDatRd[31:0]};
        end
    end

    assign dbusCyc   = (state == memWait);
    assign dbusStb   = (state == memWait);
    assign dbusWe    = (issue.memOp == rv64_pkg::memStoreDouble);
    assign dbusAdr   = {aluResult[63:3], 3'b000}; // 8-byte line
    assign dbusDatWr = issue.rs2Data;
    always_comb begin
        if (dbusWe)            dbusSel = 8'hFF;
        else if (aluResult[2]) dbusSel = 8'hF0;
        else                   dbusSel = 8'h0F;
    end

    assign retireValid = (state == retire);
    assign wbEn = retireValid && (issue.wbSrc != rv64_pkg::wbNone)
                  && !issue.halt && !issue.illegal;
    assign wbRd = issue.rd;

    always_comb begin
        case (issue.wbSrc)
            rv64_pkg::wbAlu:     wbData = aluResult;
            rv64_pkg::wbNextPc:  wbData = pcPlus4;
            rv64_pkg::wbImm:     wbData = issue.imm;
            rv64_pkg::wbMemory:  wbData = loadData;
            rv64_pkg::wbCompare: wbData = rv64_pkg::xlenT'(isLessU);
            default:             wbData = '0;
        endcase
    end

endmodule

/* hw/decode_unit.sv */
`timescale 1ns/1ps
`include "rv64_defines.svh"

module decode_unit (
    input  logic             clk,
    input  logic             arstN,
    input  logic             instValid,
    input  rv64_pkg::instT   inst,
    input  rv64_pkg::xlenT   instPc,
    input  logic             wbEn,
    input  rv64_pkg::regIdxT wbRd,
    input  rv64_pkg::xlenT   wbData,
    issue_if.issuer          issue
);

    rv64_pkg::xlenT   regFile [`REG_COUNT];
    rv64_pkg::regIdxT rs1;
    rv64_pkg::regIdxT rs2;
    rv64_pkg::regIdxT rd;
    rv64_pkg::xlenT   rs1Data;
    rv64_pkg::xlenT   rs2Data;
    rv64_pkg::xlenT   imm;
    rv64_pkg::aluOpE  aluOp;
    rv64_pkg::aluSrcE aluSrc;
    rv64_pkg::wbSrcE  wbSrc;
    rv64_pkg::pcSrcE  pcSrc;
    rv64_pkg::memOpE  memOp;
    logic             halt;
    logic             illegal;

    assign rs1 = inst[19:15];
    assign rs2 = inst[24:20];
    assign rd  = inst[11:7];

    // immediates, all sign extended from bit 31
    function automatic rv64_pkg::xlenT immI(input rv64_pkg::instT i);
        return {{52{i[31]}}, i[31:20]};
    endfunction

    function automatic rv64_pkg::xlenT immS(input rv64_pkg::instT i);
        return {{52{i[31]}}, i[31:25], i[11:7]};
    endfunction

    function automatic rv64_pkg::xlenT immB(input rv64_pkg::instT i);
        return {{52{i[31]}}, i[7], i[30:25], i[11:8], 1'b0};
    endfunction

    function automatic rv64_pkg::xlenT immU(input rv64_pkg::instT i);
        return {{32{i[31]}}, i[31:12], 12'b0};
    endfunction

    function automatic rv64_pkg::xlenT immJ(input rv64_pkg::instT i);
        return {{44{i[31]}}, i[19:12], i[20], i[30:21], 1'b0};
    endfunction

    // register file, x0 is never written
    always_ff @(posedge clk) begin
        if (wbEn && wbRd != '0) regFile[wbRd] <= wbData;
    end

    assign rs1Data = (rs1 == '0) ? '0 : regFile[rs1];
    assign rs2Data = (rs2 == '0) ? '0 : regFile[rs2];

    always_comb begin
        imm     = '0;
        aluOp   = rv64_pkg::aluNone;
        aluSrc  = rv64_pkg::srcRegReg;
        wbSrc   = rv64_pkg::wbNone;
        pcSrc   = rv64_pkg::pcSequential;
        memOp   = rv64_pkg::memNone;
        halt    = 1'b0;
        illegal = 1'b0;
        casez (inst)
            32'b0000000_?????_?????_000_?????_0111011: begin // addw
                aluOp = rv64_pkg::aluAddWord;
                wbSrc = rv64_pkg::wbAlu;
            end
            32'b0100000_?????_?????_000_?????_0110011: begin // sub
                aluOp = rv64_pkg::aluSub;
                wbSrc = rv64_pkg::wbAlu;
            end
            32'b???????_?????_?????_000_?????_0010011: begin // addi
                imm    = immI(inst);
                aluOp  = rv64_pkg::aluAdd;
                aluSrc = rv64_pkg::srcRegImm;
                wbSrc  = rv64_pkg::wbAlu;
            end
            32'b???????_?????_?????_000_?????_1100111: begin // jalr
                imm    = immI(inst);
                aluOp  = rv64_pkg::aluAddClearLsb;
                aluSrc = rv64_pkg::srcRegImm;
                wbSrc  = rv64_pkg::wbNextPc;
                pcSrc  = rv64_pkg::pcJump;
            end
            32'b000000?_?????_?????_001_?????_0010011: begin // slli, 6-bit shamt
                imm    = immI(inst);
                aluOp  = rv64_pkg::aluShiftLeft;
                aluSrc = rv64_pkg::srcRegImm;
                wbSrc  = rv64_pkg::wbAlu;
            end
            32'b???????_?????_?????_010_?????_0000011: begin // lw
                imm    = immI(inst);
                aluOp  = rv64_pkg::aluAdd;
                aluSrc = rv64_pkg::srcRegImm;
                wbSrc  = rv64_pkg::wbMemory;
                memOp  = rv64_pkg::memLoadWord;
            end
            32'b???????_?????_?????_011_?????_0010011: begin // sltiu
                imm    = immI(inst);
                aluSrc = rv64_pkg::srcRegImm;
                wbSrc  = rv64_pkg::wbCompare; // outcome settled in execute
            end
            32'b???????_?????_?????_011_?????_0100011: begin // sd
                imm    = immS(inst);
                aluOp  = rv64_pkg::aluAdd;
                aluSrc = rv64_pkg::srcRegImm;
                memOp  = rv64_pkg::memStoreDouble;
            end
            32'b???????_?????_?????_000_?????_1100011: begin // beq
                imm   = immB(inst);
                pcSrc = rv64_pkg::pcBranchEq;
            end
            32'b???????_?????_?????_001_?????_1100011: begin // bne
                imm   = immB(inst);
                pcSrc = rv64_pkg::pcBranchNe;
            end
            32'b???????_?????_?????_???_?????_0010111: begin // auipc
                imm    = immU(inst);
                aluOp  = rv64_pkg::aluAdd;
                aluSrc = rv64_pkg::srcImmPc;
                wbSrc  = rv64_pkg::wbAlu;
            end
            32'b???????_?????_?????_???_?????_0110111: begin // lui
                imm   = immU(inst);
                wbSrc = rv64_pkg::wbImm;
            end
            32'b???????_?????_?????_???_?????_1101111: begin // jal
                imm    = immJ(inst);
                aluOp  = rv64_pkg::aluAdd;
                aluSrc = rv64_pkg::srcImmPc;
                wbSrc  = rv64_pkg::wbNextPc;
                pcSrc  = rv64_pkg::pcJump;
            end
            32'b0000000_00001_00000_000_00000_1110011: halt = 1'b1; // ebreak
            default: illegal = 1'b1;
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) issue.valid <= 1'b0;
        else        issue.valid <= instValid;
    end

    // held until the next instruction, execute reads it while busy
    always_ff @(posedge clk) begin
        if (instValid) begin
            issue.pc      <= instPc;
            issue.rs1Data <= rs1Data;
            issue.rs2Data <= rs2Data;
            issue.imm     <= imm;
            issue.rd      <= rd;
            issue.aluOp   <= aluOp;
            issue.aluSrc  <= aluSrc;
            issue.wbSrc   <= wbSrc;
            issue.pcSrc   <= pcSrc;
            issue.memOp   <= memOp;
            issue.halt    <= halt;
            issue.illegal <= illegal;
        end
    end

endmodule

/* hw/fetch_stage.sv */
`timescale 1ns/1ps
`include "rv64_defines.svh"

module fetch_stage (
    input  logic           clk,
    input  logic           arstN,
    input  logic           retireValid,
    input  rv64_pkg::xlenT nextPc,
    input  logic           stop,
    output logic           ibusCyc,
    output logic           ibusStb,
    output rv64_pkg::xlenT ibusAdr,
    input  rv64_pkg::instT ibusDatRd,
    input  logic           ibusAck,
    output logic           instValid,
    output rv64_pkg::instT inst,
    output rv64_pkg::xlenT instPc
);

    typedef enum logic {
        idle,
        busRead
    } stateE;

    stateE          state;
    rv64_pkg::xlenT pc;
    logic           bootPending; // first fetch after reset still owed

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state       <= idle;
            pc          <= rv64_pkg::xlenT'(`RESET_PC);
            bootPending <= 1'b1;
            instValid   <= 1'b0;
        end else begin
            instValid <= 1'b0;
            case (state)
                idle: begin
                    if (retireValid) pc <= nextPc;
                    // halted or trapped core never fetches again
                    if ((bootPending || retireValid) && !stop) begin
                        state       <= busRead;
                        bootPending <= 1'b0;
                    end
                end
                busRead: begin
                    if (ibusAck) begin
                        state     <= idle;
                        instValid <= 1'b1;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // instruction word, captured with the ack
    always_ff @(posedge clk) begin
        if (state == busRead && ibusAck) inst <= ibusDatRd;
    end

    assign ibusCyc = (state == busRead);
    assign ibusStb = (state == busRead); // classic cycle, no bursts
    assign ibusAdr = pc;
    assign instPc  = pc; // pc only moves at retirement

endmodule

/* common/issue_if.sv */
`timescale 1ns/1ps

// one decoded instruction, decode to execute
interface issue_if;

    logic              valid;   // single cycle pulse
    rv64_pkg::xlenT    pc;
    rv64_pkg::xlenT    rs1Data;
    rv64_pkg::xlenT    rs2Data;
    rv64_pkg::xlenT    imm;
    rv64_pkg::regIdxT  rd;

    rv64_pkg::aluOpE   aluOp;
    rv64_pkg::aluSrcE  aluSrc;
    rv64_pkg::wbSrcE   wbSrc;
    rv64_pkg::pcSrcE   pcSrc;
    rv64_pkg::memOpE   memOp;

    logic              halt;    // ebreak
    logic              illegal; // no decode match

    modport issuer (
        output valid, pc, rs1Data, rs2Data, imm, rd,
        output aluOp, aluSrc, wbSrc, pcSrc, memOp,
        output halt, illegal
    );

    modport executor (
        input valid, pc, rs1Data, rs2Data, imm, rd,
        input aluOp, aluSrc, wbSrc, pcSrc, memOp,
        input halt, illegal
    );

endinterface

/* common/rv64_pkg.sv */
`include "rv64_defines.svh"

package rv64_pkg;

    typedef logic [`XLEN-1:0] xlenT;  // one data word
    typedef logic [31:0]      instT;  // raw instruction
    typedef logic [4:0]       regIdxT;

    // alu operation
    typedef enum logic [2:0] {
        aluNone        = 3'd0,
        aluAdd         = 3'd1,
        aluAddClearLsb = 3'd2, // jalr target
        aluShiftLeft   = 3'd3,
        aluAddWord     = 3'd4, // add, keep low word, sign extend
        aluSub         = 3'd5
    } aluOpE;

    // operand pair fed to the alu
    typedef enum logic [1:0] {
        srcRegReg = 2'd0, // rs1, rs2
        srcRegImm = 2'd1, // rs1, imm
        srcImmPc  = 2'd2  // imm, pc
    } aluSrcE;

    typedef enum logic [2:0] {
        wbNone    = 3'd0,
        wbAlu     = 3'd1,
        wbNextPc  = 3'd2, // link value pc+4
        wbImm     = 3'd3,
        wbMemory  = 3'd4,
        wbCompare = 3'd5  // unsigned less than, 0 or 1
    } wbSrcE;

    // next pc choice, branches resolved in execute
    typedef enum logic [1:0] {
        pcSequential = 2'd0,
        pcJump       = 2'd1,
        pcBranchEq   = 2'd2,
        pcBranchNe   = 2'd3
    } pcSrcE;

    typedef enum logic [1:0] {
        memNone        = 2'd0,
        memLoadWord    = 2'd1,
        memStoreDouble = 2'd2
    } memOpE;

endpackage

/* common/rv64_defines.svh */
`ifndef RV64_DEFINES_SVH
`define RV64_DEFINES_SVH

// data path width
`define XLEN 64

// first fetch address, widened into the 64-bit pc
`define RESET_PC 32'h0000_0000

`define REG_COUNT 32 // integer registers, x0 included

`endif
